//--- predecodePkg.sv
package predecodePkg;

  localparam int ParcelWidth = 16;
  localparam int WindowParcels = 4;   // Longest instruction in parcels
  localparam int OffsetWidth = 4;     // Enough for a 16-parcel bundle

  // Opcode fields, both read from the first parcel
  localparam int MainOpWidth = 8;
  localparam int SubOpWidth = 6;

  typedef logic [ParcelWidth-1:0] parcel_t;

  // Parcel at the start offset sits in the low bits
  typedef logic [WindowParcels*ParcelWidth-1:0] window_t;

  // Bit i set while parcel i of the window is not the last one
  typedef logic [WindowParcels-1:0] magic_t;

  typedef logic [OffsetWidth-1:0] offset_t;

  typedef logic [MainOpWidth-1:0] mainOp_t;
  typedef logic [SubOpWidth-1:0] subOp_t;

  // Execution classes, one-hot or all clear
  typedef struct packed {
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic jump;
    logic sys;
  } instrClass_t;

  // One output slot
  typedef struct packed {
    instrClass_t cls;
    magic_t      magic;
    window_t     instr;
    offset_t     off;   // Parcel index in the bundle
  } decodedInstr_t;

endpackage

//--- parcelWindow.sv
module parcelWindow #(
  parameter int NumParcels = 15
) (
  input  predecodePkg::parcel_t [NumParcels-1:0] parcels,
  input  logic [NumParcels-1:0]                  endBits,
  input  predecodePkg::offset_t                  startOff,
  output logic [NumParcels-1:0]                  isStart,
  output predecodePkg::window_t [NumParcels-1:0] windows,
  output predecodePkg::magic_t [NumParcels-1:0]  magics,
  output logic                                   startOffErr
);
  import predecodePkg::*;

  // Bundle extended so every parcel sees a full window
  localparam int PadParcels = NumParcels + WindowParcels - 1;

  parcel_t [PadParcels-1:0] padParcels;
  logic [PadParcels-1:0]    padEnds;

  always_comb begin
    padParcels = '0;
    padEnds = '0;
    padParcels[NumParcels-1:0] = parcels;
    padEnds[NumParcels-1:0] = endBits;  // Missing end bits read as zero
  end

  for (genvar k = 0; k < NumParcels; k++) begin : genParcel
    logic afterEnd;

    // Parcel 0 always begins an instruction
    if (k == 0) begin : genFirst
      assign afterEnd = 1'b1;
    end else begin : genRest
      assign afterEnd = endBits[k-1];
    end

    assign isStart[k] = afterEnd && (k >= int'(startOff));
    assign windows[k] = padParcels[k +: WindowParcels];
    assign magics[k] = ~padEnds[k +: WindowParcels];  // Padding reads as "continues"
  end

  // Offset one past the last parcel leaves nothing to decode
  assign startOffErr = (int'(startOff) == NumParcels);

endmodule

//--- instrClassifier.sv
module instrClassifier (
  input  predecodePkg::window_t     window,
  input  predecodePkg::magic_t      magic,
  output predecodePkg::instrClass_t cls
);
  import predecodePkg::*;

  mainOp_t mainOp;
  subOp_t  subOp;
  logic    longForm;

  // Long form groups
  logic longAluMul;
  logic longShift;
  logic longMem;
  logic longJump;
  logic longSys;

  // Short form groups
  logic shortBasic;
  logic shortJump;

  assign mainOp = window[MainOpWidth-1:0];
  assign subOp = window[SubOpWidth-1:0];
  assign longForm = magic[0];  // First parcel continues into a second

  assign longAluMul = (mainOp[7:5] == 3'b000) || (mainOp[7:3] == 5'b00100);
  assign longShift = (mainOp[7:1] == 7'd20) || (mainOp[7:1] == 7'd21) ||
                     (mainOp[7:1] == 7'd22);
  assign longMem = (mainOp[7:4] == 4'b0110) || (mainOp[7:4] == 4'b0111);
  assign longJump = (mainOp[7:4] == 4'b1010) || (mainOp == 8'd180) ||
                    (mainOp == 8'd181) || (mainOp == 8'd182);
  assign longSys = (mainOp == 8'hff);

  assign shortBasic = (subOp[5:4] == 2'b00);
  assign shortJump = (subOp[5:2] == 4'b1100);

  always_comb begin
    cls = '0;
    if (longForm) begin
      if (longAluMul) begin
        cls.alu = ~mainOp[2];
        cls.mul = mainOp[2];
      end else if (longShift) begin
        cls.shift = 1'b1;
      end else if (longMem) begin
        cls.load = ~mainOp[0];   // Even opcodes load
        cls.store = mainOp[0];
      end else if (longJump) begin
        cls.jump = 1'b1;
      end else if (longSys) begin
        cls.sys = 1'b1;
      end
    end else begin
      if (shortBasic) begin
        cls.alu = ~subOp[0];
        cls.shift = subOp[0];
      end else if (shortJump) begin
        cls.jump = 1'b1;
      end
    end
  end

endmodule

//--- slotCompactor.sv
module slotCompactor #(
  parameter int NumParcels = 15,
  parameter int NumSlots = 12
) (
  input  logic                                         clk,
  input  logic                                         rstN,
  input  logic                                         inValid,
  input  logic [NumParcels-1:0]                        isStart,
  input  predecodePkg::window_t [NumParcels-1:0]       windows,
  input  predecodePkg::magic_t [NumParcels-1:0]        magics,
  input  predecodePkg::instrClass_t [NumParcels-1:0]   classes,
  input  logic                                         startOffErr,
  output logic                                         outValid,
  output predecodePkg::decodedInstr_t [NumSlots-1:0]   slots,
  output logic [NumSlots-1:0]                          instrEn,
  output logic                                         hasJumps,
  output logic                                         error
);
  import predecodePkg::*;

  localparam int CountWidth = $clog2(NumParcels + 1);

  // startsBelow[k] counts starts in parcels 0..k-1
  logic [NumParcels:0][CountWidth-1:0] startsBelow;
  logic [CountWidth-1:0]               startCount;
  logic [NumParcels-1:0]               startJumps;

  decodedInstr_t [NumSlots-1:0] slotsNext;
  logic [NumSlots-1:0]          enNext;
  logic                         jumpNext;
  logic                         errNext;

  assign startsBelow[0] = '0;

  for (genvar k = 0; k < NumParcels; k++) begin : genCount
    assign startsBelow[k+1] = startsBelow[k] + CountWidth'(isStart[k]);
    assign startJumps[k] = isStart[k] & classes[k].jump;
  end

  assign startCount = startsBelow[NumParcels];

  // Parcel holding the j-th start goes to slot j
  always_comb begin
    slotsNext = '0;
    for (int j = 0; j < NumSlots; j++) begin
      enNext[j] = int'(startCount) > j;
      for (int k = 0; k < NumParcels; k++) begin
        if (isStart[k] && (int'(startsBelow[k]) == j)) begin
          slotsNext[j].cls = classes[k];
          slotsNext[j].magic = magics[k];
          slotsNext[j].instr = windows[k];
          slotsNext[j].off = offset_t'(k);
        end
      end
    end
  end

  assign jumpNext = |startJumps;  // Starts past the last slot count too
  assign errNext = (int'(startCount) > NumSlots) || startOffErr;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
      slots <= '0;
      instrEn <= '0;
      hasJumps <= 1'b0;
      error <= 1'b0;
    end else begin
      outValid <= inValid;
      if (inValid) begin
        slots <= slotsNext;
        instrEn <= enNext;
        hasJumps <= jumpNext;
        error <= errNext;
      end
    end
  end

endmodule

//--- predecoder.sv
module predecoder #(
  parameter int NumParcels = 15,
  parameter int NumSlots = 12
) (
  input  logic                                       clk,
  input  logic                                       rstN,
  input  logic                                       inValid,
  input  predecodePkg::parcel_t [NumParcels-1:0]     parcels,
  input  logic [NumParcels-1:0]                      endBits,
  input  predecodePkg::offset_t                      startOff,
  output logic                                       outValid,
  output predecodePkg::decodedInstr_t [NumSlots-1:0] slots,
  output logic [NumSlots-1:0]                        instrEn,
  output logic                                       hasJumps,
  output logic                                       error
);
  import predecodePkg::*;

  logic [NumParcels-1:0]          isStart;
  window_t [NumParcels-1:0]       windows;
  magic_t [NumParcels-1:0]        magics;
  instrClass_t [NumParcels-1:0]   classes;
  logic                           startOffErr;

  parcelWindow #(
    .NumParcels(NumParcels)
  ) i_window (
    .parcels    (parcels),
    .endBits    (endBits),
    .startOff   (startOff),
    .isStart    (isStart),
    .windows    (windows),
    .magics     (magics),
    .startOffErr(startOffErr)
  );

  // Every parcel is classified as if it began an instruction
  for (genvar k = 0; k < NumParcels; k++) begin : genClassify
    instrClassifier i_classifier (
      .window(windows[k]),
      .magic (magics[k]),
      .cls   (classes[k])
    );
  end

  slotCompactor #(
    .NumParcels(NumParcels),
    .NumSlots  (NumSlots)
  ) i_compactor (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .isStart    (isStart),
    .windows    (windows),
    .magics     (magics),
    .classes    (classes),
    .startOffErr(startOffErr),
    .outValid   (outValid),
    .slots      (slots),
    .instrEn    (instrEn),
    .hasJumps   (hasJumps),
    .error      (error)
  );

endmodule

//--- predecodeModel.svh
`ifndef PREDECODE_MODEL_SVH
`define PREDECODE_MODEL_SVH

int checkCount = 0;
int errCount = 0;

typedef struct packed {
  parcel_t [NumParcels-1:0] parcels;
  logic [NumParcels-1:0]    endBits;
  offset_t                  startOff;
} bundle_t;

// Everything the output register shows for one bundle
typedef struct packed {
  decodedInstr_t [NumSlots-1:0] slots;
  logic [NumSlots-1:0]          en;
  logic                         jump;
  logic                         err;
} result_t;

// Opcode map for one candidate start
function automatic instrClass_t classify(window_t w, magic_t m);
  instrClass_t c;
  mainOp_t op;
  subOp_t s;
  c = '0;
  op = w[7:0];
  s = w[5:0];
  if (m[0]) begin
    if (op < 8'd32 || op[7:3] == 5'b00100) begin
      c.mul = op[2];
      c.alu = !op[2];
    end else if (op >= 8'd40 && op <= 8'd45) begin
      c.shift = 1'b1;
    end else if (op >= 8'h60 && op <= 8'h7f) begin
      c.store = op[0];
      c.load = !op[0];
    end else if ((op >= 8'ha0 && op <= 8'haf) || (op >= 8'd180 && op <= 8'd182)) begin
      c.jump = 1'b1;
    end else if (op == 8'hff) begin
      c.sys = 1'b1;
    end
  end else begin
    if (s < 6'd16) begin
      c.shift = s[0];
      c.alu = !s[0];
    end else if (s >= 6'd48 && s <= 6'd51) begin
      c.jump = 1'b1;
    end
  end
  return c;
endfunction

function automatic result_t predict(bundle_t b);
  result_t r;
  decodedInstr_t d;
  int count;
  r = '0;
  count = 0;
  for (int k = 0; k < NumParcels; k++) begin
    if (k >= b.startOff && (k == 0 || b.endBits[k-1])) begin
      for (int i = 0; i < WindowParcels; i++) begin
        if (k + i < NumParcels) begin
          d.instr[i*ParcelWidth +: ParcelWidth] = b.parcels[k+i];
          d.magic[i] = !b.endBits[k+i];
        end else begin
          d.instr[i*ParcelWidth +: ParcelWidth] = '0;
          d.magic[i] = 1'b1;  // Beyond the bundle nothing ends
        end
      end
      d.off = offset_t'(k);
      d.cls = classify(d.instr, d.magic);
      if (count < NumSlots) begin
        r.slots[count] = d;
        r.en[count] = 1'b1;
      end
      r.jump = r.jump | d.cls.jump;
      count++;
    end
  end
  r.err = (count > NumSlots) || (b.startOff == NumParcels);
  return r;
endfunction

// Random lengths of one to four parcels, random payload
function automatic bundle_t randomBundle(offset_t off);
  bundle_t b;
  int pos;
  b.startOff = off;
  b.endBits = '0;
  pos = 0;
  while (pos < NumParcels) begin
    pos = pos + 1 + ($unsigned($random(seed)) % 4);
    if (pos <= NumParcels) begin
      b.endBits[pos-1] = 1'b1;
    end
  end
  for (int k = 0; k < NumParcels; k++) begin
    b.parcels[k] = parcel_t'($random(seed));
  end
  return b;
endfunction

// Same length and main opcode for every instruction
function automatic bundle_t uniformBundle(int len, mainOp_t op);
  bundle_t b;
  b = randomBundle(offset_t'(0));
  for (int k = 0; k < NumParcels; k++) begin
    b.endBits[k] = (k % len == len - 1);
    if (k % len == 0) begin
      b.parcels[k][7:0] = op;
    end
  end
  return b;
endfunction

task automatic checkSlot(int idx, decodedInstr_t exp, decodedInstr_t act);
  checkCount++;
  if (act !== exp) begin
    errCount++;
    $display("ERR slots[%0d] expected %h actual %h", idx, exp, act);
  end
endtask

task automatic checkEnables(logic [NumSlots-1:0] exp, logic [NumSlots-1:0] act);
  checkCount++;
  if (act !== exp) begin
    errCount++;
    $display("ERR instrEn expected %h actual %h", exp, act);
  end
endtask

task automatic checkFlag(string name, logic exp, logic act);
  checkCount++;
  if (act !== exp) begin
    errCount++;
    $display("ERR %s expected %h actual %h", name, exp, act);
  end
endtask

`endif

//--- tbPredecoder.sv
module tbPredecoder;
  timeunit 1ns;
  timeprecision 1ps;
  import predecodePkg::*;

  localparam int NumParcels = 15;
  localparam int NumSlots = 12;
  localparam int NumBundles = 23;
  localparam int WatchdogNs = (NumBundles + 20) * 16 * 8;

  integer seed = 32'he7be_85ff;

  logic clk;
  logic rstN;
  logic inValid;
  parcel_t [NumParcels-1:0]       parcels;
  logic [NumParcels-1:0]          endBits;
  offset_t                        startOff;
  logic                           outValid;
  decodedInstr_t [NumSlots-1:0]   slots;
  logic [NumSlots-1:0]            instrEn;
  logic                           hasJumps;
  logic                           error;

  `include "predecodeModel.svh"

  predecoder #(
    .NumParcels(NumParcels),
    .NumSlots  (NumSlots)
  ) i_predecoder (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .parcels (parcels),
    .endBits (endBits),
    .startOff(startOff),
    .outValid(outValid),
    .slots   (slots),
    .instrEn (instrEn),
    .hasJumps(hasJumps),
    .error   (error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before the tests completed");
    $display("Test FAILED");
    $finish;
  end

  task automatic compareResult(result_t e);
    for (int j = 0; j < NumSlots; j++) begin
      checkSlot(j, e.slots[j], slots[j]);
    end
    checkEnables(e.en, instrEn);
    checkFlag("hasJumps", e.jump, hasJumps);
    checkFlag("error", e.err, error);
  endtask

  task automatic driveBundle(bundle_t b);
    parcels <= b.parcels;
    endBits <= b.endBits;
    startOff <= b.startOff;
    inValid <= 1'b1;
  endtask

  // Outputs are looked at on the falling edge, away from the drive edge
  task automatic waitOutValid(output logic seen);
    seen = 1'b0;
    for (int i = 0; i < 16 && !seen; i++) begin
      @(negedge clk);
      seen = outValid;
    end
    if (!seen) begin
      errCount++;
      $display("No outValid pulse within 16 cycles of a bundle");
    end
  endtask

  task automatic runBundle(bundle_t b);
    logic seen;
    @(posedge clk);
    driveBundle(b);
    @(posedge clk);
    inValid <= 1'b0;
    waitOutValid(seen);
    if (seen) begin
      compareResult(predict(b));
    end
  endtask

  task automatic testReset();
    @(negedge clk);
    checkFlag("outValid", 1'b0, outValid);
    compareResult('0);
  endtask

  task automatic testSingleParcel();
    bundle_t b;
    b = randomBundle(offset_t'(0));
    b.endBits = '1;
    runBundle(b);
    checkEnables('1, instrEn);
    checkFlag("error", 1'b1, error);  // Fifteen starts for twelve slots
  endtask

  task automatic testMixedLengths();
    for (int i = 0; i < 6; i++) begin
      runBundle(randomBundle(offset_t'(0)));
    end
  endtask

  task automatic testStartOffset();
    int offs [3] = '{0, 5, 14};
    bundle_t b;
    foreach (offs[i]) begin
      b = randomBundle(offset_t'(offs[i]));
      if (offs[i] > 0) begin
        b.endBits[offs[i]-1] = 1'b1;
      end
      runBundle(b);
      for (int j = 0; j < NumSlots; j++) begin
        if (instrEn[j] && slots[j].off < offs[i]) begin
          errCount++;
          $display("ERR slots[%0d].off %h is below startOff %h",
                   j, slots[j].off, offset_t'(offs[i]));
        end
      end
    end
    runBundle(randomBundle(offset_t'(NumParcels)));
    checkFlag("error", 1'b1, error);
    checkEnables('0, instrEn);
  endtask

  task automatic testClasses();
    mainOp_t ops [9] = '{8'h01, 8'h24, 8'd43, 8'h62, 8'h73, 8'ha5, 8'd181, 8'hff, 8'h90};
    foreach (ops[i]) begin
      runBundle(uniformBundle(2, ops[i]));
      for (int j = 0; j < NumSlots; j++) begin
        if ($countones(slots[j].cls) > 1) begin
          errCount++;
          $display("ERR slots[%0d].cls %h has more than one flag set", j, slots[j].cls);
        end
      end
      checkFlag("hasJumps", ops[i] == 8'ha5 || ops[i] == 8'd181, hasJumps);
    end
  endtask

  task automatic testBackToBack();
    bundle_t b [3];
    logic seen;
    foreach (b[i]) begin
      b[i] = randomBundle(offset_t'(i * 3));
    end
    @(posedge clk);
    driveBundle(b[0]);
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i < 2) begin
        driveBundle(b[i+1]);
      end else begin
        // Other inputs while idle, so a held result differs from a fresh decode
        parcels <= b[0].parcels;
        endBits <= b[0].endBits;
        startOff <= b[0].startOff;
        inValid <= 1'b0;
      end
      waitOutValid(seen);
      if (seen) begin
        compareResult(predict(b[i]));
      end
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkFlag("outValid", 1'b0, outValid);
    compareResult(predict(b[2]));  // Last result still held
  endtask

  initial begin
    rstN = 1'b0;
    inValid = 1'b0;
    parcels = '0;
    endBits = '0;
    startOff = '0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    testReset();
    testSingleParcel();
    testMixedLengths();
    testStartOffset();
    testClasses();
    testBackToBack();
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
predecodePkg.sv
parcelWindow.sv
instrClassifier.sv
slotCompactor.sv
predecoder.sv
tbPredecoder.sv
